// File: logic/debug_pkg.sv
`default_nettype none

package debug_pkg;

    // retired data is shown in full on the hex display with one nibble per digit
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 32;

    localparam int HEX_DIGITS = 8;
    localparam int SEG_WIDTH  = 7;  // segments a to g with no decimal point

    // the core runs until it retires, then waits for the operator
    typedef enum logic [0:0] {
        STEP_RUN  = 1'b0,
        STEP_HALT = 1'b1
    } step_state_t;

endpackage

`default_nettype wire

// File: logic/retire_if.sv
`timescale 1ns/1ns
`default_nettype none

interface retire_if #(
    parameter int OPTN_REGMAP_DEPTH = 32
) ();

    import debug_pkg::*;

    localparam int RDEST_WIDTH = $clog2(OPTN_REGMAP_DEPTH);

    logic                   retire_en;
    logic [RDEST_WIDTH-1:0] retire_rdest;
    logic [DATA_WIDTH-1:0]  retire_data;
    logic                   redirect;       // sticky flag on the held side
    logic [ADDR_WIDTH-1:0]  redirect_addr;

    modport src (
        output retire_en,
        output retire_rdest,
        output retire_data,
        output redirect,
        output redirect_addr
    );

    modport snk (
        input  retire_en,
        input  retire_rdest,
        input  retire_data,
        input  redirect,
        input  redirect_addr
    );

endinterface

`default_nettype wire

// File: logic/key_edge_detector.sv
`timescale 1ns/1ns
`default_nettype none

module key_edge_detector #(
    parameter int OPTN_SYNC_STAGES = 2
) (
    input  logic clk,
    input  logic n_rst,
    input  logic i_key_n,
    output logic o_pulse
);

    logic [OPTN_SYNC_STAGES-1:0] sync_q;
    logic                        key_level;
    logic                        key_level_q;

    assign key_level = sync_q[OPTN_SYNC_STAGES-1];  // pressed level that is safe in the clk domain

    // shift chain for the asynchronous button
    always_ff @(posedge clk) begin
        if (~n_rst) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[OPTN_SYNC_STAGES-2:0], ~i_key_n};
        end
    end

    // a held key keeps key_level high, so only the first cycle fires
    always_ff @(posedge clk) begin
        if (~n_rst) begin
            key_level_q <= 1'b0;
            o_pulse     <= 1'b0;
        end else begin
            key_level_q <= key_level;
            o_pulse     <= key_level & ~key_level_q;
        end
    end

endmodule

`default_nettype wire

// File: logic/retire_capture.sv
`timescale 1ns/1ns
`default_nettype none

module retire_capture #(
    parameter int OPTN_REGMAP_DEPTH = 32
) (
    input  logic  clk,
    input  logic  n_rst,
    retire_if.snk live,
    retire_if.src held
);

    import debug_pkg::*;

    localparam int RDEST_WIDTH = $clog2(OPTN_REGMAP_DEPTH);

    logic                   retire_en_q;
    logic [RDEST_WIDTH-1:0] rdest_q;
    logic [DATA_WIDTH-1:0]  data_q;
    logic                   redirect_q;
    logic [ADDR_WIDTH-1:0]  redirect_addr_q;

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            retire_en_q     <= 1'b0;
            rdest_q         <= '0;
            data_q          <= '0;
            redirect_q      <= 1'b0;
            redirect_addr_q <= '0;
        end else begin
            retire_en_q <= live.retire_en;  // one cycle activity strobe

            if (live.retire_en) begin
                rdest_q <= live.retire_rdest;
                data_q  <= live.retire_data;
            end

            // a new redirect wins over the retire that would clear the flag
            if (live.redirect) begin
                redirect_q      <= 1'b1;
                redirect_addr_q <= live.redirect_addr;
            end else if (live.retire_en) begin
                redirect_q <= 1'b0;
            end
        end
    end

    assign held.retire_en     = retire_en_q;
    assign held.retire_rdest  = rdest_q;
    assign held.retire_data   = data_q;
    assign held.redirect      = redirect_q;
    assign held.redirect_addr = redirect_addr_q;  // kept after the flag clears

endmodule

`default_nettype wire

// File: logic/step_controller.sv
`timescale 1ns/1ns
`default_nettype none

module step_controller (
    input  logic                   clk,
    input  logic                   n_rst,
    input  logic                   i_free_run,
    input  logic                   i_retire_en,
    input  logic                   i_key_pulse,
    output logic                   o_core_en,
    output debug_pkg::step_state_t o_state
);

    import debug_pkg::*;

    step_state_t state;
    step_state_t state_next;

    always_comb begin
        state_next = state;

        case (state)
            STEP_RUN:  state_next = i_retire_en ? STEP_HALT : STEP_RUN;
            STEP_HALT: state_next = i_key_pulse ? STEP_RUN : STEP_HALT;  // core is frozen here
            default:   state_next = STEP_RUN;
        endcase

        if (i_free_run) begin
            state_next = STEP_RUN;  // also releases a core that was already halted
        end
    end

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            state <= STEP_RUN;
        end else begin
            state <= state_next;
        end
    end

    // enable comes straight from the state flop so it drops on the edge after the retire
    assign o_core_en = (state == STEP_RUN);
    assign o_state   = state;

endmodule

`default_nettype wire

// File: logic/seg7_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module seg7_decoder (
    input  logic                           n_rst,
    input  logic [3:0]                     i_hex,
    output logic [debug_pkg::SEG_WIDTH-1:0] o_seg
);

    import debug_pkg::*;

    // segments are active low and ordered {g, f, e, d, c, b, a}
    always_comb begin
        case (i_hex)
            4'h0:    o_seg = 7'b1000000;
            4'h1:    o_seg = 7'b1111001;
            4'h2:    o_seg = 7'b0100100;
            4'h3:    o_seg = 7'b0110000;
            4'h4:    o_seg = 7'b0011001;
            4'h5:    o_seg = 7'b0010010;
            4'h6:    o_seg = 7'b0000010;
            4'h7:    o_seg = 7'b1111000;
            4'h8:    o_seg = 7'b0000000;
            4'h9:    o_seg = 7'b0010000;
            4'ha:    o_seg = 7'b0001000;
            4'hb:    o_seg = 7'b0000011;  // lower case b because an upper case B would read as 8
            4'hc:    o_seg = 7'b1000110;
            4'hd:    o_seg = 7'b0100001;
            4'he:    o_seg = 7'b0000110;
            4'hf:    o_seg = 7'b0001110;
            default: o_seg = {SEG_WIDTH{1'b1}};
        endcase

        if (~n_rst) begin
            o_seg = {SEG_WIDTH{1'b1}};  // display dark while the board is held in reset
        end
    end

endmodule

`default_nettype wire

// File: logic/debug_harness.sv
`timescale 1ns/1ns
`default_nettype none

module debug_harness #(
    parameter int OPTN_REGMAP_DEPTH = 32,
    parameter int OPTN_SYNC_STAGES  = 2
) (
    input  logic                                 clk,
    input  logic                                 n_rst,

    input  logic                                 i_key_n,
    input  logic                                 i_free_run,

    input  logic                                 i_retire_en,
    input  logic [$clog2(OPTN_REGMAP_DEPTH)-1:0] i_retire_rdest,
    input  logic [debug_pkg::DATA_WIDTH-1:0]     i_retire_data,
    input  logic                                 i_redirect,
    input  logic [debug_pkg::ADDR_WIDTH-1:0]     i_redirect_addr,

    output logic                                 o_core_en,

    output logic [17:0]                          o_ledr,
    output logic [7:0]                           o_ledg,

    output logic [debug_pkg::SEG_WIDTH-1:0]      o_hex0,
    output logic [debug_pkg::SEG_WIDTH-1:0]      o_hex1,
    output logic [debug_pkg::SEG_WIDTH-1:0]      o_hex2,
    output logic [debug_pkg::SEG_WIDTH-1:0]      o_hex3,
    output logic [debug_pkg::SEG_WIDTH-1:0]      o_hex4,
    output logic [debug_pkg::SEG_WIDTH-1:0]      o_hex5,
    output logic [debug_pkg::SEG_WIDTH-1:0]      o_hex6,
    output logic [debug_pkg::SEG_WIDTH-1:0]      o_hex7
);

    import debug_pkg::*;

    logic                 key_pulse;
    step_state_t          state;
    logic [SEG_WIDTH-1:0] hex_seg [HEX_DIGITS];

    retire_if #(
        .OPTN_REGMAP_DEPTH(OPTN_REGMAP_DEPTH)
    ) live_retire ();

    retire_if #(
        .OPTN_REGMAP_DEPTH(OPTN_REGMAP_DEPTH)
    ) held_retire ();

    // the core's retire and redirect outputs as they arrive
    assign live_retire.retire_en     = i_retire_en;
    assign live_retire.retire_rdest  = i_retire_rdest;
    assign live_retire.retire_data   = i_retire_data;
    assign live_retire.redirect      = i_redirect;
    assign live_retire.redirect_addr = i_redirect_addr;

    key_edge_detector #(
        .OPTN_SYNC_STAGES(OPTN_SYNC_STAGES)
    ) key_edge_detector_inst (
        .clk(clk),
        .n_rst(n_rst),
        .i_key_n(i_key_n),
        .o_pulse(key_pulse)
    );

    retire_capture #(
        .OPTN_REGMAP_DEPTH(OPTN_REGMAP_DEPTH)
    ) retire_capture_inst (
        .clk(clk),
        .n_rst(n_rst),
        .live(live_retire.snk),
        .held(held_retire.src)
    );

    step_controller step_controller_inst (
        .clk(clk),
        .n_rst(n_rst),
        .i_free_run(i_free_run),
        .i_retire_en(live_retire.retire_en),
        .i_key_pulse(key_pulse),
        .o_core_en(o_core_en),
        .o_state(state)
    );

    // digit i shows nibble i of the held data and hex0 is the least significant
    genvar i;
    generate
        for (i = 0; i < HEX_DIGITS; i++) begin : SEG7_DECODER_INSTANCES
            seg7_decoder seg7_decoder_inst (
                .n_rst(n_rst),
                .i_hex(held_retire.retire_data[i*4 +: 4]),
                .o_seg(hex_seg[i])
            );
        end
    endgenerate

    assign o_hex0 = hex_seg[0];
    assign o_hex1 = hex_seg[1];
    assign o_hex2 = hex_seg[2];
    assign o_hex3 = hex_seg[3];
    assign o_hex4 = hex_seg[4];
    assign o_hex5 = hex_seg[5];
    assign o_hex6 = hex_seg[6];
    assign o_hex7 = hex_seg[7];

    assign o_ledr[17]   = (state == STEP_HALT);
    assign o_ledr[16]   = held_retire.redirect;
    assign o_ledr[15:0] = held_retire.redirect_addr[15:0];  // low half fits the red bank
    assign o_ledg       = 8'(held_retire.retire_rdest);     // unused upper LEDs stay dark

endmodule

`default_nettype wire

// File: verif/tb_debug_harness.sv
`timescale 1ns/1ns
`default_nettype none

module tb_debug_harness #(
    parameter int SEED = 28
);

    import debug_pkg::*;

    localparam int REGMAP_DEPTH   = 32;
    localparam int SYNC_STAGES    = 2;
    localparam int RDEST_WIDTH    = $clog2(REGMAP_DEPTH);
    localparam int STEP_COUNT     = 20;
    localparam int FREE_RUN_COUNT = 12;
    localparam int HOLD_CYCLES    = 10;
    localparam int WAIT_LIMIT     = 50;

    logic                   clk;
    logic                   n_rst;
    logic                   i_key_n;
    logic                   i_free_run;
    logic                   i_retire_en;
    logic [RDEST_WIDTH-1:0] i_retire_rdest;
    logic [DATA_WIDTH-1:0]  i_retire_data;
    logic                   i_redirect;
    logic [ADDR_WIDTH-1:0]  i_redirect_addr;
    logic                   o_core_en;
    logic [17:0]            o_ledr;
    logic [7:0]             o_ledg;
    logic [SEG_WIDTH-1:0]   o_hex0, o_hex1, o_hex2, o_hex3;
    logic [SEG_WIDTH-1:0]   o_hex4, o_hex5, o_hex6, o_hex7;

    int error_count;
    int protocol_errors;
    int errors_at_start;
    int tests_run;
    int tests_failed;

    debug_harness #(
        .OPTN_REGMAP_DEPTH(REGMAP_DEPTH),
        .OPTN_SYNC_STAGES(SYNC_STAGES)
    ) uut (
        .clk(clk), .n_rst(n_rst), .i_key_n(i_key_n), .i_free_run(i_free_run),
        .i_retire_en(i_retire_en), .i_retire_rdest(i_retire_rdest),
        .i_retire_data(i_retire_data), .i_redirect(i_redirect),
        .i_redirect_addr(i_redirect_addr), .o_core_en(o_core_en),
        .o_ledr(o_ledr), .o_ledg(o_ledg),
        .o_hex0(o_hex0), .o_hex1(o_hex1), .o_hex2(o_hex2), .o_hex3(o_hex3),
        .o_hex4(o_hex4), .o_hex5(o_hex5), .o_hex6(o_hex6), .o_hex7(o_hex7)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // the core must stay frozen while the harness holds it
    core_obeys_enable: assert property (@(posedge clk) disable iff (!n_rst)
        i_retire_en |-> o_core_en)
    else begin
        protocol_errors++;
        $display("core model retired at %0t while the core enable was low", $time);
    end

    // active low segments in {g, f, e, d, c, b, a} order
    function automatic logic [6:0] glyph(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            4'ha: return 7'b0001000;
            4'hb: return 7'b0000011;
            4'hc: return 7'b1000110;
            4'hd: return 7'b0100001;
            4'he: return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    function automatic logic [6:0] digit_out(input int index);
        case (index)
            0: return o_hex0;
            1: return o_hex1;
            2: return o_hex2;
            3: return o_hex3;
            4: return o_hex4;
            5: return o_hex5;
            6: return o_hex6;
            default: return o_hex7;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            error_count++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_digits(input logic [31:0] data, input logic blank);
        int i;
        logic [6:0] expected;
        for (i = 0; i < HEX_DIGITS; i++) begin
            expected = blank ? 7'h7f : glyph(data[i*4 +: 4]);
            check_value($sformatf("o_hex%0d", i), 32'(expected), 32'(digit_out(i)));
        end
    endtask

    task automatic abort_run(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("tests failed");
        $finish;
    endtask

    // the core model only retires while the harness lets it run
    task automatic core_retire(input logic [RDEST_WIDTH-1:0] rdest, input logic [31:0] data,
                               input logic redirect, input logic [31:0] addr);
        int waited;
        waited = 0;
        while (!o_core_en) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) abort_run("core enable never rose for the next retire");
        end
        i_retire_en     = 1'b1;
        i_retire_rdest  = rdest;
        i_retire_data   = data;
        i_redirect      = redirect;
        i_redirect_addr = addr;
        @(negedge clk);
        i_retire_en = 1'b0;
        i_redirect  = 1'b0;
    endtask

    task automatic check_halted(input logic [RDEST_WIDTH-1:0] rdest, input logic [31:0] data);
        check_value("o_core_en", 32'(1'b0), 32'(o_core_en));
        check_value("o_ledr[17]", 32'(1'b1), 32'(o_ledr[17]));
        check_value("o_ledg", 32'(rdest), 32'(o_ledg));
        check_digits(data, 1'b0);
    endtask

    task automatic press_key_until_resume();
        int waited;
        waited = 0;
        i_key_n = 1'b0;  // held until release_key
        while (!o_core_en) begin
            @(negedge clk);
            waited++;
            if (waited > SYNC_STAGES + 2) abort_run("key press did not resume the core");
        end
    endtask

    task automatic release_key();
        i_key_n = 1'b1;
        repeat (SYNC_STAGES + 2) @(negedge clk);  // let the synchronizer see the release
    endtask

    task automatic finish_test(input int number, input string name);
        int errors;
        errors = error_count + protocol_errors - errors_at_start;
        tests_run++;
        if (errors != 0) tests_failed++;
        $display("test %0d %s: %s, %0d errors", number, name, (errors == 0) ? "ok" : "FAILED",
                 errors);
        errors_at_start = error_count + protocol_errors;
    endtask

    initial begin
        logic [RDEST_WIDTH-1:0] rdest;
        logic [31:0]            data;
        logic [31:0]            addr;
        int                     k;

        n_rst = 1'b0;
        i_key_n = 1'b1;
        i_free_run = 1'b0;
        i_retire_en = 1'b0;
        i_retire_rdest = '0;
        i_retire_data = '0;
        i_redirect = 1'b0;
        i_redirect_addr = '0;
        error_count = 0;
        protocol_errors = 0;
        errors_at_start = 0;
        tests_run = 0;
        tests_failed = 0;
        void'($urandom(SEED));

        repeat (15) @(negedge clk);
        check_digits(32'h0, 1'b1);  // dark while reset is still held
        @(negedge clk);
        n_rst = 1'b1;
        @(negedge clk);
        check_value("o_core_en", 32'(1'b1), 32'(o_core_en));
        check_value("o_ledg", 32'h0, 32'(o_ledg));
        check_value("o_ledr[17:16]", 32'h0, 32'(o_ledr[17:16]));
        check_digits(32'h0, 1'b0);
        finish_test(1, "reset state");

        rdest = RDEST_WIDTH'($urandom % REGMAP_DEPTH);
        data  = $urandom;
        core_retire(rdest, data, 1'b0, 32'h0);
        check_halted(rdest, data);
        finish_test(2, "halt on retire");

        // key stays down through the next halt and must not step again
        press_key_until_resume();
        rdest = RDEST_WIDTH'($urandom % REGMAP_DEPTH);
        data  = $urandom;
        core_retire(rdest, data, 1'b0, 32'h0);
        check_halted(rdest, data);
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            check_value("o_core_en", 32'(1'b0), 32'(o_core_en));
        end
        release_key();
        for (k = 0; k < STEP_COUNT; k++) begin
            press_key_until_resume();
            release_key();
            rdest = RDEST_WIDTH'($urandom % REGMAP_DEPTH);
            data  = $urandom;
            core_retire(rdest, data, 1'b0, 32'h0);
            check_halted(rdest, data);
        end
        finish_test(3, "resume on key");

        press_key_until_resume();
        release_key();
        addr  = $urandom;
        rdest = RDEST_WIDTH'($urandom % REGMAP_DEPTH);
        data  = $urandom;
        core_retire(rdest, data, 1'b1, addr);
        check_halted(rdest, data);
        check_value("o_ledr[16]", 32'(1'b1), 32'(o_ledr[16]));
        check_value("o_ledr[15:0]", 32'(addr[15:0]), 32'(o_ledr[15:0]));
        press_key_until_resume();
        release_key();
        core_retire(rdest, data, 1'b0, 32'h0);
        check_value("o_ledr[16]", 32'(1'b0), 32'(o_ledr[16]));
        press_key_until_resume();
        release_key();
        finish_test(4, "redirect flag");

        i_free_run = 1'b1;
        for (k = 0; k < FREE_RUN_COUNT; k++) begin
            data           = $urandom;
            i_retire_en    = 1'b1;
            i_retire_rdest = RDEST_WIDTH'($urandom % REGMAP_DEPTH);
            i_retire_data  = data;
            @(negedge clk);
            check_value("o_core_en", 32'(1'b1), 32'(o_core_en));
            check_digits(data, 1'b0);
        end
        i_retire_en = 1'b0;
        @(negedge clk);
        check_value("o_core_en", 32'(1'b1), 32'(o_core_en));
        check_value("o_ledr[17]", 32'(1'b0), 32'(o_ledr[17]));
        check_digits(data, 1'b0);
        i_free_run = 1'b0;
        finish_test(5, "free run");

        $display("%0d tests run, %0d failed, %0d value errors, %0d protocol errors",
                 tests_run, tests_failed, error_count, protocol_errors);
        if (tests_failed == 0 && error_count == 0 && protocol_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
logic/debug_pkg.sv
logic/retire_if.sv
logic/key_edge_detector.sv
logic/retire_capture.sv
logic/step_controller.sv
logic/seg7_decoder.sv
logic/debug_harness.sv
verif/tb_debug_harness.sv

// File: Makefile
# Verilator flow for the single-step debug harness
# any variable below can be overridden, for example: make sim SEED=5 LOG=run5.log

VERILATOR ?= verilator
FILELIST  ?= sources.f
TOP       ?= tb_debug_harness
RTL_TOP   ?= debug_harness
SEED      ?= 28
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= all tests passed

SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

# lint the design on its own, the testbench is parsed but not elaborated
lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) \
		--top-module $(TOP) -GSEED=$(SEED) -Mdir $(OBJ_DIR) -o V$(TOP)

# the run status is ignored, the log decides pass or fail
sim: build
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || \
		(echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
